// File: Makefile
# Verilator build and run for the memory address generator

VERILATOR ?= verilator
TOP       ?= tb_mem_agen
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

# sources from the file list, plus included headers
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
+incdir+verification
rtl/agen_isa_pkg.sv
rtl/agen_cfg_pkg.sv
rtl/agen_dec_if.sv
rtl/index_scaler.sv
rtl/disp_decoder.sv
rtl/addr_combiner.sv
rtl/mem_agen.sv
verification/tb_mem_agen.sv

// File: rtl/addr_combiner.sv
module addr_combiner (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            issue,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] a,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] base,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] offset,
	input  logic [agen_cfg_pkg::CX_W-1:0]   cx,
	agen_dec_if.comb                        dec,
	output logic [agen_cfg_pkg::ADDR_W-1:0] ma,
	output logic                            ma_valid
);

	import agen_cfg_pkg::*;

	// ==========================================================================
	// term masking and sum
	// ==========================================================================

	logic [ADDR_W-1:0] base_a_term;
	logic [ADDR_W-1:0] index_term;
	logic [ADDR_W-1:0] offset_term;
	logic [ADDR_W-1:0] adj_term;
	logic [ADDR_W-1:0] sum;
	logic [ADDR_W-1:0] ma_next;

	assign base_a_term = dec.add_base_a ? base + a : '0;

	// scaled index carry above the address width wraps away
	assign index_term  = dec.add_index ? cx[ADDR_W-1:0] : '0;
	assign offset_term = dec.add_offset ? offset : '0;
	assign adj_term    = dec.push_adj ? ADDR_W'(PUSH_ADJ) : '0;

	// everything wraps at the address width
	assign sum = base_a_term + index_term + dec.disp + offset_term - adj_term;

	// amo bypasses the adder
	assign ma_next = dec.pass_a ? a : sum;

	// ==========================================================================
	// result register
	// ==========================================================================

	// one cycle from issue to result, last address held otherwise
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ma       <= '0;
			ma_valid <= 1'b0;
		end else begin
			ma_valid <= issue;
			if (issue) begin
				ma <= ma_next;
			end
		end
	end

endmodule

// File: rtl/agen_cfg_pkg.sv
package agen_cfg_pkg;

	// ==========================================================================
	// address datapath
	// ==========================================================================

	// effective address width, all sums wrap here
	localparam int ADDR_W = 64;

	// scaled index keeps one extra carry bit
	localparam int CX_W = ADDR_W + 1;

	// stack pre-decrement applied by push
	localparam int unsigned PUSH_ADJ = 16;

	// index scale codes
	// codes 5 and 6 are reserved and scale by one
	typedef enum logic [2:0] {
		SC_X1  = 3'd0,
		SC_X2  = 3'd1,
		SC_X4  = 3'd2,
		SC_X8  = 3'd3,
		SC_X16 = 3'd4,
		SC_X5  = 3'd7
	} scale_e;

endpackage

// File: rtl/agen_dec_if.sv
interface agen_dec_if;

	import agen_cfg_pkg::*;

	// displacement, already extended to full address width
	logic [ADDR_W-1:0] disp;
	// include the scaled index
	logic add_index;
	// include the external offset
	logic add_offset;
	// include segment base and register a
	logic add_base_a;
	// subtract the push adjustment
	logic push_adj;
	// address is register a with nothing added
	logic pass_a;

	// decoder side
	modport dec (output disp, add_index, add_offset, add_base_a, push_adj, pass_a);

	// combiner side
	modport comb (input disp, add_index, add_offset, add_base_a, push_adj, pass_a);

endinterface

// File: rtl/agen_isa_pkg.sv
package agen_isa_pkg;

	// ==========================================================================
	// instruction word
	// ==========================================================================

	// every instruction is 40 bits wide
	localparam int INST_W = 40;

	// primary opcode sits in the lowest six bits
	localparam int OP_LSB = 0;
	localparam int OP_W   = 6;

	// addressing mode select bit
	localparam int AM_BIT = 7;

	// low five immediate bits of the store layout
	localparam int STORE_LO_LSB = 8;
	localparam int LO_W         = 5;

	// index scale field, width comes from the scale code type
	localparam int SCALE_LSB = 13;

	// low five immediate bits of the load layout
	localparam int LOAD_LO_LSB = 18;

	// store long form continues right above the load low bits
	localparam int STORE_HI_LSB = LOAD_LO_LSB + LO_W;

	// top four immediate bits shared by both short forms
	localparam int IMM_HI_LSB = 33;
	localparam int IMM_HI_W   = 4;

	// msb of every long immediate, also its sign
	localparam int SIGN_BIT = 36;

	// long immediates are 19 bits and signed
	localparam int LONG_IMM_W  = SIGN_BIT - LOAD_LO_LSB + 1;
	// short immediates are 9 bits and unsigned
	localparam int SHORT_IMM_W = IMM_HI_W + LO_W;

	// ==========================================================================
	// opcodes of the load/store subset
	// ==========================================================================

	// anything not listed here is a non-memory instruction
	typedef enum logic [OP_W-1:0] {
		OP_LOAD  = 6'h20,
		OP_AMO   = 6'h21,
		OP_STORE = 6'h28,
		OP_LEA   = 6'h29,
		OP_PUSH  = 6'h2a,
		OP_PUSHC = 6'h2b
	} op_e;

	// addressing mode, register plus displacement or plus scaled index
	typedef enum logic {
		AM_DISP  = 1'b0,
		AM_INDEX = 1'b1
	} am_e;

endpackage

// File: rtl/disp_decoder.sv
module disp_decoder (
	input  logic [agen_isa_pkg::INST_W-1:0] inst,
	agen_dec_if.dec                         dec
);

	import agen_isa_pkg::*;
	import agen_cfg_pkg::*;

	// ==========================================================================
	// field extraction
	// ==========================================================================

	op_e op;
	am_e am;

	// opcode groups
	logic is_load;
	logic is_store;
	// indexed form only exists for memory instructions
	logic indexed;

	// immediate candidates in both bit layouts
	logic [ADDR_W-1:0] ld_long;
	logic [ADDR_W-1:0] st_long;
	logic [ADDR_W-1:0] ld_short;
	logic [ADDR_W-1:0] st_short;
	// layout picked by opcode group
	logic [ADDR_W-1:0] imm_long;
	logic [ADDR_W-1:0] imm_short;

	// raw field casts, unlisted opcode values are fine here
	assign op = op_e'(inst[OP_LSB +: OP_W]);
	assign am = am_e'(inst[AM_BIT]);

	assign is_load  = op inside {OP_LOAD, OP_AMO};
	assign is_store = op inside {OP_STORE, OP_LEA, OP_PUSH, OP_PUSHC};
	assign indexed  = (is_load || is_store) && (am == AM_INDEX);

	// load long form is one contiguous 19 bit field
	assign ld_long = {{(ADDR_W - LONG_IMM_W){inst[SIGN_BIT]}},
		inst[SIGN_BIT:LOAD_LO_LSB]};

	// store long form splits its low bits off to the register slot
	assign st_long = {{(ADDR_W - LONG_IMM_W){inst[SIGN_BIT]}},
		inst[SIGN_BIT:STORE_HI_LSB], inst[STORE_LO_LSB +: LO_W]};

	// short forms are zero extended
	assign ld_short = ADDR_W'({inst[IMM_HI_LSB +: IMM_HI_W], inst[LOAD_LO_LSB +: LO_W]});
	assign st_short = ADDR_W'({inst[IMM_HI_LSB +: IMM_HI_W], inst[STORE_LO_LSB +: LO_W]});

	// non-memory ops fall in the load layout
	assign imm_long  = is_store ? st_long : ld_long;
	assign imm_short = is_store ? st_short : ld_short;

	// ==========================================================================
	// add-term selection
	// ==========================================================================

	always_comb begin
		// common case
		// base + a + displacement, plus index or plus offset
		dec.disp       = indexed ? imm_short : imm_long;
		dec.add_index  = indexed;
		dec.add_offset = !indexed;
		dec.add_base_a = 1'b1;
		dec.push_adj   = 1'b0;
		dec.pass_a     = 1'b0;

		case (op)
			OP_AMO: begin
				// atomic goes straight to the address in a
				dec.disp       = '0;
				dec.add_index  = 1'b0;
				dec.add_offset = 1'b0;
				dec.add_base_a = 1'b0;
				dec.pass_a     = 1'b1;
			end
			OP_LEA: begin
				// store forms, offset left out
				dec.add_offset = 1'b0;
			end
			OP_PUSH, OP_PUSHC: begin
				// pre-decrement the stack pointer
				dec.disp       = '0;
				dec.add_index  = 1'b0;
				dec.add_offset = 1'b0;
				dec.push_adj   = 1'b1;
			end
			default: begin
				// loads, stores and non-memory keep the common case
			end
		endcase
	end

endmodule

// File: rtl/index_scaler.sv
module index_scaler (
	input  logic [agen_cfg_pkg::ADDR_W-1:0] c,
	input  agen_cfg_pkg::scale_e            scale,
	output logic [agen_cfg_pkg::CX_W-1:0]   cx
);

	import agen_cfg_pkg::*;

	// index widened by one bit so the scaled carry survives
	logic [CX_W-1:0] c_ext;

	assign c_ext = CX_W'(c);

	// ==========================================================================
	// scale select
	// ==========================================================================

	always_comb begin
		case (scale)
			SC_X1: begin
				cx = c_ext;
			end
			SC_X2: begin
				cx = c_ext << 1;
			end
			SC_X4: begin
				cx = c_ext << 2;
			end
			SC_X8: begin
				cx = c_ext << 3;
			end
			SC_X16: begin
				cx = c_ext << 4;
			end
			SC_X5: begin
				// times four plus one copy
				cx = (c_ext << 2) + c_ext;
			end
			default: begin
				// reserved codes pass the index unscaled
				cx = c_ext;
			end
		endcase
	end

endmodule

// File: rtl/mem_agen.sv
module mem_agen (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            issue,
	input  logic [agen_isa_pkg::INST_W-1:0] inst,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] a,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] c,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] base,
	input  logic [agen_cfg_pkg::ADDR_W-1:0] offset,
	output logic [agen_cfg_pkg::ADDR_W-1:0] ma,
	output logic                            ma_valid
);

	import agen_isa_pkg::*;
	import agen_cfg_pkg::*;

	// decoder to combiner bundle
	agen_dec_if dec_if ();

	// scaled index into the combiner
	logic [CX_W-1:0] cx;
	// scale field as a code
	scale_e scale;

	assign scale = scale_e'(inst[SCALE_LSB +: $bits(scale_e)]);

	// scaler and decoder work on the same instruction in parallel
	index_scaler u_index_scaler (
		.c     (c),
		.scale (scale),
		.cx    (cx)
	);

	disp_decoder u_disp_decoder (
		.inst (inst),
		.dec  (dec_if)
	);

	// adds the selected terms and registers the address
	addr_combiner u_addr_combiner (
		.clk      (clk),
		.arst_n   (arst_n),
		.issue    (issue),
		.a        (a),
		.base     (base),
		.offset   (offset),
		.cx       (cx),
		.dec      (dec_if),
		.ma       (ma),
		.ma_valid (ma_valid)
	);

endmodule

// File: verification/agen_ref_model.svh
`ifndef AGEN_REF_MODEL_SVH
`define AGEN_REF_MODEL_SVH

// ==========================================================================
// opcode values of the load/store subset
// ==========================================================================

localparam logic [5:0] REF_LOAD  = 6'h20;
localparam logic [5:0] REF_AMO   = 6'h21;
localparam logic [5:0] REF_STORE = 6'h28;
localparam logic [5:0] REF_LEA   = 6'h29;
localparam logic [5:0] REF_PUSH  = 6'h2a;
localparam logic [5:0] REF_PUSHC = 6'h2b;

// push moves the stack pointer down by this much first
localparam logic [63:0] STACK_STEP = 64'd16;

// multiplier for a scale code
// reserved codes 5 and 6 count as one
function automatic logic [63:0] scale_factor(input logic [2:0] code);
	case (code)
		3'd0: return 64'd1;
		3'd1: return 64'd2;
		3'd2: return 64'd4;
		3'd3: return 64'd8;
		3'd4: return 64'd16;
		3'd7: return 64'd5;
		default: return 64'd1;
	endcase
endfunction

// effective address, all arithmetic modulo 2^64
function automatic logic [63:0] expected_addr(input logic [39:0] inst, input logic [63:0] a,
	input logic [63:0] c, input logic [63:0] base, input logic [63:0] offset);
	logic        indexed;
	logic [63:0] cx;
	logic [63:0] long_ld;
	logic [63:0] long_st;
	logic [63:0] short_ld;
	logic [63:0] short_st;
	indexed  = inst[7];
	cx       = c * scale_factor(inst[15:13]);
	// 19 bit signed forms
	long_ld  = {{45{inst[36]}}, inst[36:18]};
	long_st  = {{45{inst[36]}}, inst[36:23], inst[12:8]};
	// 9 bit unsigned forms
	short_ld = {55'd0, inst[36:33], inst[22:18]};
	short_st = {55'd0, inst[36:33], inst[12:8]};
	case (inst[5:0])
		REF_AMO: return a;
		REF_PUSH, REF_PUSHC: return base + a - STACK_STEP;
		REF_LOAD: return indexed ? base + a + cx + short_ld : base + a + long_ld + offset;
		REF_STORE: return indexed ? base + a + cx + short_st : base + a + long_st + offset;
		REF_LEA: return indexed ? base + a + cx + short_st : base + a + long_st;
		// non-memory, mode bit has no effect
		default: return base + a + long_ld + offset;
	endcase
endfunction

// ==========================================================================
// instruction builders
// ==========================================================================

// contiguous 19 bit immediate at bits 36:18, mode bit clear
function automatic logic [39:0] load_disp_inst(input logic [5:0] op, input logic [18:0] imm);
	logic [39:0] w;
	w        = '0;
	w[5:0]   = op;
	w[36:18] = imm;
	return w;
endfunction

// low five immediate bits moved down to 12:8
function automatic logic [39:0] store_disp_inst(input logic [5:0] op, input logic [18:0] imm);
	logic [39:0] w;
	w        = '0;
	w[5:0]   = op;
	w[36:23] = imm[18:5];
	w[12:8]  = imm[4:0];
	return w;
endfunction

// indexed, short immediate split over 36:33 and 22:18
function automatic logic [39:0] load_index_inst(input logic [5:0] op, input logic [2:0] scale,
	input logic [8:0] imm);
	logic [39:0] w;
	w        = '0;
	w[5:0]   = op;
	w[7]     = 1'b1;
	w[15:13] = scale;
	w[36:33] = imm[8:5];
	w[22:18] = imm[4:0];
	return w;
endfunction

// indexed, short immediate split over 36:33 and 12:8
function automatic logic [39:0] store_index_inst(input logic [5:0] op, input logic [2:0] scale,
	input logic [8:0] imm);
	logic [39:0] w;
	w        = '0;
	w[5:0]   = op;
	w[7]     = 1'b1;
	w[15:13] = scale;
	w[36:33] = imm[8:5];
	w[12:8]  = imm[4:0];
	return w;
endfunction

`endif

// File: verification/tb_mem_agen.sv
module tb_mem_agen;

	timeunit 1ns;
	timeprecision 100ps;

	`include "agen_ref_model.svh"

	// ==========================================================================
	// run length
	// ==========================================================================

	localparam int RESET_CYCLES  = 3;
	// directed sends plus idles stay below this
	localparam int DIRECTED_MAX  = 60;
	localparam int RANDOM_ISSUES = 400;
	localparam int MAX_GAP       = 3;
	// worst case length with a fifth on top
	// reset is applied twice
	localparam int CYCLE_LIMIT =
		(2 * RESET_CYCLES + DIRECTED_MAX + RANDOM_ISSUES * (MAX_GAP + 1)) * 6 / 5;

	logic        clk;
	logic        arst_n;
	logic        issue;
	logic [39:0] inst;
	logic [63:0] a;
	logic [63:0] c;
	logic [63:0] base;
	logic [63:0] offset;
	logic [63:0] ma;
	logic        ma_valid;

	integer seed;
	int     cycle_count = 0;
	// set once the first issue after reset has been sampled
	logic   seen_issue;

	mem_agen u_mem_agen (
		.clk      (clk),
		.arst_n   (arst_n),
		.issue    (issue),
		.inst     (inst),
		.a        (a),
		.c        (c),
		.base     (base),
		.offset   (offset),
		.ma       (ma),
		.ma_valid (ma_valid)
	);

	// 20 ns period
	always #10 clk = ~clk;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seen_issue <= 1'b0;
		end else if (issue) begin
			seen_issue <= 1'b1;
		end
	end

	// hard stop on a stuck run
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// ==========================================================================
	// checks
	// ==========================================================================

	// quiet outputs through reset and up to the first result
	reset_quiet: assert property (@(posedge clk) !seen_issue |-> (!ma_valid && ma == '0))
		else report_failure("ma_valid or ma not cleared before the first issue");

	valid_after_issue: assert property (@(posedge clk) disable iff (!arst_n)
		issue |=> ma_valid)
		else report_failure("ma_valid low in the cycle after an issue");

	// address from the inputs sampled one edge earlier
	addr_matches: assert property (@(posedge clk) disable iff (!arst_n)
		issue |=> ma == expected_addr($past(inst), $past(a), $past(c), $past(base),
		$past(offset)))
		else report_failure("ma does not match the reference address");

	// without an issue the valid drops and the old address stays
	hold_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!issue |=> (!ma_valid && ma == $past(ma)))
		else report_failure("ma_valid raised or ma changed without an issue");

	// ==========================================================================
	// stimulus driven on the falling edge
	// ==========================================================================

	task automatic random_word(output logic [63:0] v);
		v = {$random(seed), $random(seed)};
	endtask

	task automatic send_ops(input logic [39:0] word, input logic [63:0] va,
		input logic [63:0] vc, input logic [63:0] vbase, input logic [63:0] voffset);
		issue  = 1'b1;
		inst   = word;
		a      = va;
		c      = vc;
		base   = vbase;
		offset = voffset;
		@(negedge clk);
	endtask

	task automatic send(input logic [39:0] word);
		logic [63:0] va;
		logic [63:0] vc;
		logic [63:0] vbase;
		logic [63:0] voffset;
		random_word(va);
		random_word(vc);
		random_word(vbase);
		random_word(voffset);
		send_ops(word, va, vc, vbase, voffset);
	endtask

	// inputs keep moving so a held ma shows up
	task automatic idle(input int cycles);
		logic [63:0] bits;
		repeat (cycles) begin
			random_word(bits);
			issue = 1'b0;
			inst  = bits[39:0];
			random_word(a);
			random_word(c);
			random_word(base);
			random_word(offset);
			@(negedge clk);
		end
	endtask

	// weighted toward the six memory opcodes
	task automatic random_inst(output logic [39:0] word);
		logic [63:0] bits;
		int          pick;
		random_word(bits);
		word = bits[39:0];
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: word[5:0] = REF_LOAD;
			1: word[5:0] = REF_AMO;
			2: word[5:0] = REF_STORE;
			3: word[5:0] = REF_LEA;
			4: word[5:0] = REF_PUSH;
			5: word[5:0] = REF_PUSHC;
			default: begin
				// force a non-memory value
				if (word[5:0] inside {REF_LOAD, REF_AMO, REF_STORE,
					REF_LEA, REF_PUSH, REF_PUSHC}) begin
					word[5:0] = 6'h3f;
				end
			end
		endcase
	endtask

	initial begin
		logic [39:0] word;
		int          gap;
		seed   = 32'h0130_e307;
		clk    = 1'b0;
		arst_n = 1'b0;
		issue  = 1'b0;
		inst   = '0;
		a      = '0;
		c      = '0;
		base   = '0;
		offset = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		idle(2);

		// displacement loads and non-memory ops with both signs
		send(load_disp_inst(REF_LOAD, 19'h1_2345));
		send(load_disp_inst(REF_LOAD, 19'h7_fff0));
		send(load_disp_inst(6'h05, 19'h0_0abc));
		send(load_disp_inst(6'h3f, 19'h4_0001));
		// mode bit means nothing outside the memory group
		send(load_disp_inst(6'h12, 19'h5_5555) | 40'h80);
		idle(1);

		// every scale code in both indexed layouts back to back
		for (int s = 0; s < 8; s++) begin
			send(load_index_inst(REF_LOAD, 3'(s), 9'h1a5));
		end
		for (int s = 0; s < 8; s++) begin
			send(store_index_inst(REF_STORE, 3'(s), 9'h0d3));
		end
		idle(1);

		// store adds offset and lea drops it
		send(store_disp_inst(REF_STORE, 19'h0_1234));
		send(store_disp_inst(REF_STORE, 19'h7_ff01));
		send(store_disp_inst(REF_LEA, 19'h2_0f0f));
		send(store_disp_inst(REF_LEA, 19'h6_0000));
		send(store_index_inst(REF_LEA, 3'd3, 9'h1ff));
		send(store_index_inst(REF_LEA, 3'd7, 9'h021));
		idle(2);

		// push forms ignore immediate and mode
		send(store_disp_inst(REF_PUSH, 19'h3_3333));
		send(store_index_inst(REF_PUSH, 3'd4, 9'h155));
		send(store_disp_inst(REF_PUSHC, 19'h7_ffff));
		// amo is a alone
		send(load_disp_inst(REF_AMO, 19'h1_1111));
		send(load_index_inst(REF_AMO, 3'd2, 9'h0aa));
		idle(3);

		// wrap cases around zero
		send_ops(load_disp_inst(REF_LOAD, 19'h7_ffff), 64'hffff_ffff_ffff_fff0, 64'd0,
			64'h20, 64'h1);
		send_ops(load_index_inst(REF_LOAD, 3'd4, 9'h000), 64'd0, 64'hf000_0000_0000_0001,
			64'h8, 64'd0);
		send_ops(store_disp_inst(REF_PUSH, 19'h0_0000), 64'd0, 64'd0, 64'd0, 64'd0);
		idle(2);

		// second reset clears a nonzero address even with issue held high
		arst_n = 1'b0;
		issue  = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		idle(2);

		// random mix with random gaps
		for (int n = 0; n < RANDOM_ISSUES; n++) begin
			random_inst(word);
			send(word);
			gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			idle(gap);
		end
		idle(2);

		$display("All tests passed");
		$finish;
	end

endmodule
